// ==== bench/reg_interface_tb.sv ====
/*
 * Testbench for the host register block.
 * Random host bus traffic against VRAM and XR memory models, with
 * register, stream, mem_wait and timer checks.
 */

`default_nettype none
`timescale 1ns/1ps

module reg_interface_tb
    import xv_pkg::*;
();

    localparam int CLK_HZ      = 210000;        // one timer tick per 21 clk
    localparam int TICK_CYCLES = 21;
    localparam int N_STREAM    = 12;            // words per stream test
    localparam int LONG_DELAY  = 16;            // ack late enough to span one bus access
    localparam int TIMEOUT_NS  = 2_000_000;     // 2 ms, far past the ~100 us of traffic

    logic       clk, reset_i;
    logic       bus_cs_n_i, bus_rd_nwr_i, bus_bytesel_i;
    logic [3:0] bus_reg_num_i;
    byte_t      bus_data_i, bus_data_o;
    logic       vram_sel_o, vram_wr_o, vram_ack_i;
    logic       xr_sel_o, xr_wr_o, xr_ack_i;
    addr_t      vram_addr_o, xr_addr_o;
    word_t      vram_data_o, vram_data_i, xr_data_o, xr_data_i;

    integer     seed;                           // shared $random seed
    int         force_delay = 0;                // 0 gives random ack delay
    int         cycle_count = 0;                // posedges since start
    word_t      vram_mem [0:65535];
    word_t      xr_mem [0:65535];
    addr_t      vram_wr_addr_q[$], xr_wr_addr_q[$];     // writes seen at ack
    word_t      vram_wr_data_q[$], xr_wr_data_q[$];

    tb_clock #(.PERIOD_NS(10)) u_clock (.clk_o(clk));

    reg_interface #(.CLK_HZ(CLK_HZ)) DUT (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
        .vram_sel_o(vram_sel_o), .vram_wr_o(vram_wr_o),
        .vram_addr_o(vram_addr_o), .vram_data_o(vram_data_o),
        .vram_data_i(vram_data_i), .vram_ack_i(vram_ack_i),
        .xr_sel_o(xr_sel_o), .xr_wr_o(xr_wr_o),
        .xr_addr_o(xr_addr_o), .xr_data_o(xr_data_o),
        .xr_data_i(xr_data_i), .xr_ack_i(xr_ack_i)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic stop_on_error;
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("mismatch time=%0d ns %s expected %h actual %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            $display("mismatch time=%0d ns %s expected %h actual %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("mismatch time=%0d ns %s expected %h actual %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    // one host access, entered on a falling edge: 6 cycles selected, 4 idle
    task automatic bus_access(input logic rd, input logic [3:0] num, input logic bsel,
                              input byte_t wdata, output byte_t rdata);
        bus_rd_nwr_i  = rd;
        bus_reg_num_i = num;
        bus_bytesel_i = bsel;
        bus_data_i    = wdata;
        bus_cs_n_i    = 1'b0;
        repeat (3) @(negedge clk);
        rdata = bus_data_o;                     // same cycle the timer latch samples
        repeat (3) @(negedge clk);
        bus_cs_n_i = 1'b1;                      // other inputs stay put
        repeat (4) @(negedge clk);
    endtask

    task automatic write_reg(input logic [3:0] num, input word_t value);
        byte_t ignored;
        bus_access(1'b0, num, 1'b0, value[15:8], ignored);     // even byte first
        bus_access(1'b0, num, 1'b1, value[7:0], ignored);
    endtask

    task automatic read_reg(input logic [3:0] num, output word_t value);
        byte_t hi, lo;
        bus_access(1'b1, num, 1'b0, 8'h00, hi);
        bus_access(1'b1, num, 1'b1, 8'h00, lo);
        value = {hi, lo};
    endtask

    // poll SYS_CTRL until mem_wait drops
    task automatic wait_mem_idle;
        byte_t status;
        int    tries;
        tries  = 0;
        status = 8'h80;
        while (status[7]) begin
            bus_access(1'b1, SYS_CTRL, 1'b0, 8'h00, status);
            tries++;
            if (tries > 20) begin
                $display("mem_wait still set after %0d polls", tries);
                stop_on_error();
            end
        end
    endtask

    task automatic roundtrip(input logic [3:0] num, input string name, input word_t bump);
        word_t value, got;
        value = word_t'($random(seed));
        write_reg(num, value);
        wait_mem_idle();
        read_reg(num, got);
        check_word(name, value + bump, got);    // bump for XR read auto increment
    endtask

    task automatic read_timer(output word_t count, output int mark);
        mark = cycle_count;                     // latch follows at a fixed offset
        read_reg(TIMER, count);
    endtask

    // VRAM model, ack after 1 to 4 cycles or a forced delay
    initial begin : vram_model
        int delay;
        vram_ack_i  = 1'b0;
        vram_data_i = 16'h0000;
        forever begin
            @(negedge clk);
            if (vram_sel_o) begin
                delay = (force_delay != 0) ? force_delay : 1 + ({$random(seed)} % 4);
                repeat (delay - 1) @(negedge clk);
                if (vram_wr_o) begin
                    vram_wr_addr_q.push_back(vram_addr_o);
                    vram_wr_data_q.push_back(vram_data_o);
                    vram_mem[vram_addr_o] = vram_data_o;
                end
                vram_data_i = vram_mem[vram_addr_o];
                vram_ack_i  = 1'b1;             // seen on one rising edge
                @(negedge clk);
                vram_ack_i  = 1'b0;
            end
        end
    end

    // XR model, same handshake
    initial begin : xr_model
        int delay;
        xr_ack_i  = 1'b0;
        xr_data_i = 16'h0000;
        forever begin
            @(negedge clk);
            if (xr_sel_o) begin
                delay = (force_delay != 0) ? force_delay : 1 + ({$random(seed)} % 4);
                repeat (delay - 1) @(negedge clk);
                if (xr_wr_o) begin
                    xr_wr_addr_q.push_back(xr_addr_o);
                    xr_wr_data_q.push_back(xr_data_o);
                    xr_mem[xr_addr_o] = xr_data_o;
                end
                xr_data_i = xr_mem[xr_addr_o];
                xr_ack_i  = 1'b1;
                @(negedge clk);
                xr_ack_i  = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout, the test sequence did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation FAILED");
        $fatal(1);
    end

    initial begin : stimulus
        word_t      value, start, incr, got, expw, diff, ticks_lo, c0, c1;
        byte_t      status;
        logic [3:0] data_num;
        int         t0, t1;
        seed          = 63898;
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = 4'h0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = 8'h00;
        for (int i = 0; i < 65536; i++) begin
            vram_mem[i] = word_t'($random(seed));
            xr_mem[i]   = word_t'($random(seed));
        end
        repeat (3) @(negedge clk);
        reset_i = 1'b0;

        // plain registers read back, RD_XADDR one past after its read
        roundtrip(RD_INCR, "RD_INCR", 16'd0);
        roundtrip(WR_INCR, "WR_INCR", 16'd0);
        roundtrip(WR_ADDR, "WR_ADDR", 16'd0);
        roundtrip(RD_XADDR, "RD_XADDR", 16'd1);
        roundtrip(WR_XADDR, "WR_XADDR", 16'd0);
        for (int n = 1; n < 16; n++) begin
            if (n == 1 || n >= 12) begin
                read_reg(4'(n), got);
                check_word("unused register", 16'h0000, got);
            end
        end

        // VRAM write stream
        start = word_t'($random(seed));
        incr  = word_t'($random(seed));
        write_reg(WR_ADDR, start);
        write_reg(WR_INCR, incr);
        expw = start;
        for (int k = 0; k < N_STREAM; k++) begin
            value = word_t'($random(seed));
            data_num = ($random(seed) & 1) ? DATA_2 : DATA;     // either alias
            write_reg(data_num, value);
            wait_mem_idle();
            if (vram_wr_addr_q.size() != 1) begin
                $display("expected one VRAM write, saw %0d", vram_wr_addr_q.size());
                stop_on_error();
            end
            check_addr("vram_addr_o", expw, vram_wr_addr_q.pop_front());
            check_word("vram_data_o", value, vram_wr_data_q.pop_front());
            expw = expw + incr;
        end
        read_reg(WR_ADDR, got);
        check_word("WR_ADDR after stream", expw, got);

        // VRAM read stream, each low byte read fetches the next word
        start = word_t'($random(seed));
        incr  = word_t'($random(seed));
        write_reg(RD_INCR, incr);
        write_reg(RD_ADDR, start);
        wait_mem_idle();
        expw = start;
        for (int k = 0; k < N_STREAM; k++) begin
            data_num = ($random(seed) & 1) ? DATA_2 : DATA;
            read_reg(data_num, got);
            wait_mem_idle();
            check_word("DATA", vram_mem[expw], got);
            expw = expw + incr;
        end
        read_reg(RD_ADDR, got);
        check_word("RD_ADDR after stream", expw + incr, got);   // one pre-read ahead
        if (vram_wr_addr_q.size() != 0) begin
            $display("VRAM write request seen during the read stream");
            stop_on_error();
        end

        // XR writes at consecutive addresses
        start = word_t'($random(seed));
        write_reg(WR_XADDR, start);
        expw = start;
        for (int k = 0; k < N_STREAM; k++) begin
            value = word_t'($random(seed));
            write_reg(XDATA, value);
            wait_mem_idle();
            if (xr_wr_addr_q.size() != 1) begin
                $display("expected one XR write, saw %0d", xr_wr_addr_q.size());
                stop_on_error();
            end
            check_addr("xr_addr_o", expw, xr_wr_addr_q.pop_front());
            check_word("xr_data_o", value, xr_wr_data_q.pop_front());
            expw = expw + 16'd1;
        end
        read_reg(WR_XADDR, got);
        check_word("WR_XADDR after stream", expw, got);

        // XR read
        start = word_t'($random(seed));
        write_reg(RD_XADDR, start);
        wait_mem_idle();
        read_reg(XDATA, got);
        check_word("XDATA", xr_mem[start], got);
        read_reg(RD_XADDR, got);
        check_word("RD_XADDR after read", start + 16'd1, got);
        if (xr_wr_addr_q.size() != 0) begin
            $display("XR write request seen during the XR read");
            stop_on_error();
        end

        // mem_wait while a slow VRAM read is outstanding
        force_delay = LONG_DELAY;
        write_reg(RD_ADDR, word_t'($random(seed)));
        bus_access(1'b1, SYS_CTRL, 1'b0, 8'h00, status);
        check_byte("mem_wait pending", 8'h80, status);
        force_delay = 0;
        wait_mem_idle();
        bus_access(1'b1, SYS_CTRL, 1'b0, 8'h00, status);
        check_byte("mem_wait idle", 8'h00, status);

        // timer advance between two reads
        for (int k = 0; k < 3; k++) begin
            read_timer(c0, t0);
            repeat (100 + {$random(seed)} % 1000) @(negedge clk);
            read_timer(c1, t1);
            diff     = c1 - c0;
            ticks_lo = word_t'((t1 - t0) / TICK_CYCLES);
            if (diff != ticks_lo + 16'd1) begin
                check_word("timer ticks", ticks_lo, diff);  // one extra tick allowed
            end
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
/*
 * Testbench clock source.
 * Free running clk with a fixed period, starting low.
 */

`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 10                // full clock period
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;    // half period per edge
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/xv_pkg.sv
rtl/bus_sync.sv
rtl/tick_timer.sv
rtl/vram_port.sv
rtl/xr_port.sv
rtl/reg_interface.sv
bench/tb_clock.sv
bench/reg_interface_tb.sv

// ==== rtl/bus_sync.sv ====
/*
 * Host bus synchronizer.
 * Brings the async 8-bit host bus into the clk domain and turns the
 * falling edge of select into a one cycle read or write strobe.
 */

`default_nettype none
`timescale 1ns/1ps

module bus_sync
    import xv_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       bus_cs_n_i,         // async select, low active
    input  wire logic       bus_rd_nwr_i,       // 1 for read
    input  wire logic [3:0] bus_reg_num_i,      // async register number
    input  wire logic       bus_bytesel_i,      // 0 even/high byte
    input  wire byte_t      bus_data_i,         // async write byte
    output      logic       write_strobe_o,     // one cycle per write access
    output      logic       read_strobe_o,      // one cycle per read access
    output      reg_num_t   reg_num_o,          // synced register number
    output      logic       bytesel_o,          // synced byte select
    output      byte_t      data_byte_o         // synced write byte
);

    logic       cs_meta, cs_sync, cs_last;      // select pipe plus edge history
    logic       rd_nwr_meta, rd_nwr_sync;
    logic [3:0] reg_num_meta, reg_num_sync;
    logic       bytesel_meta, bytesel_sync;
    byte_t      data_meta, data_sync;
    logic       cs_fall;                        // select just went active

    assign cs_fall     = cs_last & ~cs_sync;
    assign reg_num_o   = reg_num_t'(reg_num_sync);
    assign bytesel_o   = bytesel_sync;
    assign data_byte_o = data_sync;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_meta        <= 1'b1;             // idle bus is deselected
            cs_sync        <= 1'b1;
            cs_last        <= 1'b1;
            rd_nwr_meta    <= 1'b0;
            rd_nwr_sync    <= 1'b0;
            reg_num_meta   <= 4'h0;
            reg_num_sync   <= 4'h0;
            bytesel_meta   <= 1'b0;
            bytesel_sync   <= 1'b0;
            data_meta      <= 8'h00;
            data_sync      <= 8'h00;
            write_strobe_o <= 1'b0;
            read_strobe_o  <= 1'b0;
        end else begin
            cs_meta        <= bus_cs_n_i;       // first stage
            cs_sync        <= cs_meta;          // second stage
            cs_last        <= cs_sync;
            rd_nwr_meta    <= bus_rd_nwr_i;
            rd_nwr_sync    <= rd_nwr_meta;
            reg_num_meta   <= bus_reg_num_i;
            reg_num_sync   <= reg_num_meta;
            bytesel_meta   <= bus_bytesel_i;
            bytesel_sync   <= bytesel_meta;
            data_meta      <= bus_data_i;
            data_sync      <= data_meta;
            write_strobe_o <= cs_fall & ~rd_nwr_sync;   // qualified by direction
            read_strobe_o  <= cs_fall & rd_nwr_sync;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/reg_interface.sv ====
/*
 * Host register block of the video controller.
 * Synchronizes the 8-bit host bus, muxes register reads onto it and
 * hands writes to the VRAM and XR ports. Also owns the timer latch.
 */

`default_nettype none
`timescale 1ns/1ps

module reg_interface
    import xv_pkg::*;
#(
    parameter int CLK_HZ = 25_000_000           // clk rate, passed to the timer
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       bus_cs_n_i,         // host select, low active
    input  wire logic       bus_rd_nwr_i,       // 1 for read
    input  wire logic [3:0] bus_reg_num_i,
    input  wire logic       bus_bytesel_i,      // 0 even/high byte
    input  wire byte_t      bus_data_i,
    output      byte_t      bus_data_o,
    output      logic       vram_sel_o,
    output      logic       vram_wr_o,
    output      addr_t      vram_addr_o,
    output      word_t      vram_data_o,
    input  wire word_t      vram_data_i,
    input  wire logic       vram_ack_i,
    output      logic       xr_sel_o,
    output      logic       xr_wr_o,
    output      addr_t      xr_addr_o,
    output      word_t      xr_data_o,
    input  wire word_t      xr_data_i,
    input  wire logic       xr_ack_i
);

    logic       write_strobe, read_strobe;
    reg_num_t   reg_num;                        // synced register number
    logic       bytesel;
    byte_t      data_byte;
    word_t      timer_count;
    byte_t      timer_latch;                    // low byte frozen at even read
    word_t      rd_incr, rd_addr, wr_incr, wr_addr, rd_data;
    word_t      rd_xaddr, wr_xaddr, rd_xdata;
    logic       vram_busy, xr_busy;
    logic       mem_wait;                       // any memory request pending
    word_t      rd_word;                        // word behind the selected register

    assign mem_wait   = vram_busy | xr_busy;
    assign bus_data_o = bytesel ? rd_word[7:0] : rd_word[15:8];

    always_comb begin
        case (reg_num)
            SYS_CTRL: rd_word = {mem_wait, 15'h0000};
            TIMER:    rd_word = {timer_count[15:8], timer_latch};  // live high, latched low
            RD_XADDR: rd_word = rd_xaddr;
            WR_XADDR: rd_word = wr_xaddr;
            XDATA:    rd_word = rd_xdata;
            RD_INCR:  rd_word = rd_incr;
            RD_ADDR:  rd_word = rd_addr;
            WR_INCR:  rd_word = wr_incr;
            WR_ADDR:  rd_word = wr_addr;
            DATA,
            DATA_2:   rd_word = rd_data;
            default:  rd_word = 16'h0000;       // unused numbers read zero
        endcase
    end

    // any even byte read freezes the timer low byte
    always_ff @(posedge clk) begin
        if (reset_i) begin
            timer_latch <= 8'h00;
        end else if (read_strobe && !bytesel) begin
            timer_latch <= timer_count[7:0];
        end
    end

    bus_sync u_bus_sync (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i),
        .write_strobe_o(write_strobe), .read_strobe_o(read_strobe),
        .reg_num_o(reg_num), .bytesel_o(bytesel), .data_byte_o(data_byte)
    );

    tick_timer #(.CLK_HZ(CLK_HZ)) u_tick_timer (
        .clk(clk), .reset_i(reset_i), .count_o(timer_count)
    );

    vram_port u_vram_port (
        .clk(clk), .reset_i(reset_i),
        .write_strobe_i(write_strobe), .read_strobe_i(read_strobe),
        .reg_num_i(reg_num), .bytesel_i(bytesel), .data_byte_i(data_byte),
        .vram_ack_i(vram_ack_i), .vram_data_i(vram_data_i),
        .vram_sel_o(vram_sel_o), .vram_wr_o(vram_wr_o),
        .vram_addr_o(vram_addr_o), .vram_data_o(vram_data_o),
        .rd_incr_o(rd_incr), .rd_addr_o(rd_addr),
        .wr_incr_o(wr_incr), .wr_addr_o(wr_addr),
        .rd_data_o(rd_data), .busy_o(vram_busy)
    );

    xr_port u_xr_port (
        .clk(clk), .reset_i(reset_i),
        .write_strobe_i(write_strobe), .reg_num_i(reg_num),
        .bytesel_i(bytesel), .data_byte_i(data_byte),
        .xr_ack_i(xr_ack_i), .xr_data_i(xr_data_i),
        .xr_sel_o(xr_sel_o), .xr_wr_o(xr_wr_o),
        .xr_addr_o(xr_addr_o), .xr_data_o(xr_data_o),
        .rd_xaddr_o(rd_xaddr), .wr_xaddr_o(wr_xaddr),
        .rd_xdata_o(rd_xdata), .busy_o(xr_busy)
    );

endmodule

`default_nettype wire

// ==== rtl/tick_timer.sv ====
/*
 * Free running tenth millisecond timer.
 * A fraction counter divides clk and bumps a 16-bit count on wrap.
 */

`default_nettype none
`timescale 1ns/1ps

module tick_timer
    import xv_pkg::*;
#(
    parameter int CLK_HZ = 25_000_000           // clk rate from the top
) (
    input  wire logic   clk,
    input  wire logic   reset_i,
    output      word_t  count_o                 // tenth ms count
);

    localparam int FRAC_TERM = CLK_HZ / TIMER_HZ - 1;   // last fraction value
    localparam int FRAC_W    = (FRAC_TERM < 1) ? 1 : $clog2(FRAC_TERM + 1);

    logic [FRAC_W-1:0] frac;                    // clk cycles within one tick

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frac    <= '0;
            count_o <= 16'h0000;
        end else if (frac == FRAC_W'(FRAC_TERM)) begin
            frac    <= '0;                      // wrap and tick
            count_o <= count_o + 16'd1;
        end else begin
            frac    <= frac + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/vram_port.sv ====
/*
 * VRAM side of the host registers.
 * Holds read/write address and increment, the pre-read data word,
 * and drives the sel/ack request toward VRAM.
 */

`default_nettype none
`timescale 1ns/1ps

module vram_port
    import xv_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       write_strobe_i,     // host byte write
    input  wire logic       read_strobe_i,      // host byte read
    input  wire reg_num_t   reg_num_i,
    input  wire logic       bytesel_i,          // 0 even/high byte
    input  wire byte_t      data_byte_i,
    input  wire logic       vram_ack_i,         // one cycle, ends request
    input  wire word_t      vram_data_i,        // read data, valid with ack
    output      logic       vram_sel_o,
    output      logic       vram_wr_o,
    output      addr_t      vram_addr_o,
    output      word_t      vram_data_o,
    output      word_t      rd_incr_o,          // RD_INCR
    output      word_t      rd_addr_o,          // RD_ADDR
    output      word_t      wr_incr_o,          // WR_INCR
    output      word_t      wr_addr_o,          // WR_ADDR
    output      word_t      rd_data_o,          // last word read from VRAM
    output      logic       busy_o              // request outstanding
);

    byte_t  data_even;                          // high byte waiting for its pair
    logic   data_reg;                           // DATA or its alias
    logic   wr_even, wr_odd;
    logic   addr_rd_go;                         // RD_ADDR low byte starts read
    logic   data_wr_go;                         // DATA low byte starts write
    logic   pre_rd_go;                          // DATA low byte read, fetch next

    assign data_reg   = (reg_num_i == DATA) || (reg_num_i == DATA_2);
    assign wr_even    = write_strobe_i & ~bytesel_i;
    assign wr_odd     = write_strobe_i & bytesel_i;
    assign addr_rd_go = wr_odd && (reg_num_i == RD_ADDR);
    assign data_wr_go = wr_odd && data_reg;
    assign pre_rd_go  = read_strobe_i && bytesel_i && data_reg;
    assign busy_o     = vram_sel_o;             // sel stays up until ack

    // control and host visible registers
    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o <= 1'b0;
            vram_wr_o  <= 1'b0;
            rd_incr_o  <= 16'h0000;
            rd_addr_o  <= 16'h0000;
            wr_incr_o  <= 16'h0000;
            wr_addr_o  <= 16'h0000;
            rd_data_o  <= 16'h0000;
        end else begin
            if (vram_sel_o && vram_ack_i) begin
                if (vram_wr_o) begin
                    wr_addr_o <= wr_addr_o + wr_incr_o;     // step to next write
                end else begin
                    rd_data_o <= vram_data_i;               // capture on ack
                    rd_addr_o <= rd_addr_o + rd_incr_o;     // step to next read
                end
                vram_sel_o <= 1'b0;
                vram_wr_o  <= 1'b0;
            end

            case (reg_num_i)
                RD_INCR: begin
                    if (wr_even) rd_incr_o[15:8] <= data_byte_i;
                    if (wr_odd)  rd_incr_o[7:0]  <= data_byte_i;
                end
                RD_ADDR: begin
                    if (wr_even) rd_addr_o[15:8] <= data_byte_i;
                    if (wr_odd)  rd_addr_o[7:0]  <= data_byte_i;
                end
                WR_INCR: begin
                    if (wr_even) wr_incr_o[15:8] <= data_byte_i;
                    if (wr_odd)  wr_incr_o[7:0]  <= data_byte_i;
                end
                WR_ADDR: begin
                    if (wr_even) wr_addr_o[15:8] <= data_byte_i;
                    if (wr_odd)  wr_addr_o[7:0]  <= data_byte_i;
                end
                default: ;                      // other registers live elsewhere
            endcase

            if (addr_rd_go || pre_rd_go) begin
                vram_sel_o <= 1'b1;             // read request
            end
            if (data_wr_go) begin
                vram_sel_o <= 1'b1;             // write request
                vram_wr_o  <= 1'b1;
            end
        end
    end

    // request address and data, held until the ack
    always_ff @(posedge clk) begin
        if (wr_even && data_reg) begin
            data_even <= data_byte_i;
        end
        if (addr_rd_go) begin
            vram_addr_o <= {rd_addr_o[15:8], data_byte_i};  // new address, read now
        end
        if (pre_rd_go) begin
            vram_addr_o <= rd_addr_o;           // already stepped by last ack
        end
        if (data_wr_go) begin
            vram_addr_o <= wr_addr_o;
            vram_data_o <= {data_even, data_byte_i};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/xr_port.sv ====
/*
 * XR side of the host registers.
 * XR read/write addresses with auto increment by one per access,
 * the XR read data word and the sel/ack request toward XR.
 */

`default_nettype none
`timescale 1ns/1ps

module xr_port
    import xv_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       write_strobe_i,     // host byte write
    input  wire reg_num_t   reg_num_i,
    input  wire logic       bytesel_i,          // 0 even/high byte
    input  wire byte_t      data_byte_i,
    input  wire logic       xr_ack_i,           // one cycle, ends request
    input  wire word_t      xr_data_i,          // read data, valid with ack
    output      logic       xr_sel_o,
    output      logic       xr_wr_o,
    output      addr_t      xr_addr_o,
    output      word_t      xr_data_o,
    output      word_t      rd_xaddr_o,         // RD_XADDR
    output      word_t      wr_xaddr_o,         // WR_XADDR
    output      word_t      rd_xdata_o,         // last word read from XR
    output      logic       busy_o              // request outstanding
);

    byte_t  xdata_even;                         // high byte waiting for its pair
    logic   wr_even, wr_odd;
    logic   xrd_go;                             // RD_XADDR low byte starts read
    logic   xwr_go;                             // XDATA low byte starts write

    assign wr_even = write_strobe_i & ~bytesel_i;
    assign wr_odd  = write_strobe_i & bytesel_i;
    assign xrd_go  = wr_odd && (reg_num_i == RD_XADDR);
    assign xwr_go  = wr_odd && (reg_num_i == XDATA);
    assign busy_o  = xr_sel_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            xr_sel_o   <= 1'b0;
            xr_wr_o    <= 1'b0;
            rd_xaddr_o <= 16'h0000;
            wr_xaddr_o <= 16'h0000;
            rd_xdata_o <= 16'h0000;
        end else begin
            if (xr_sel_o && xr_ack_i) begin
                if (xr_wr_o) begin
                    wr_xaddr_o <= wr_xaddr_o + 16'd1;
                end else begin
                    rd_xdata_o <= xr_data_i;    // capture on ack
                    rd_xaddr_o <= rd_xaddr_o + 16'd1;
                end
                xr_sel_o <= 1'b0;
                xr_wr_o  <= 1'b0;
            end

            if (reg_num_i == RD_XADDR) begin
                if (wr_even) rd_xaddr_o[15:8] <= data_byte_i;
                if (wr_odd)  rd_xaddr_o[7:0]  <= data_byte_i;
            end
            if (reg_num_i == WR_XADDR) begin
                if (wr_even) wr_xaddr_o[15:8] <= data_byte_i;
                if (wr_odd)  wr_xaddr_o[7:0]  <= data_byte_i;
            end

            if (xrd_go) begin
                xr_sel_o <= 1'b1;               // read request
            end
            if (xwr_go) begin
                xr_sel_o <= 1'b1;               // write request
                xr_wr_o  <= 1'b1;
            end
        end
    end

    // request address and data, held until the ack
    always_ff @(posedge clk) begin
        if (wr_even && (reg_num_i == XDATA)) begin
            xdata_even <= data_byte_i;
        end
        if (xrd_go) begin
            xr_addr_o <= {rd_xaddr_o[15:8], data_byte_i};
        end
        if (xwr_go) begin
            xr_addr_o <= wr_xaddr_o;
            xr_data_o <= {xdata_even, data_byte_i};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/xv_pkg.sv ====
/*
 * Shared types for the video controller host register block.
 * Word, address and byte types, register numbers and the timer rate.
 */

`default_nettype none

package xv_pkg;

    typedef logic [15:0] word_t;        // register or memory data word
    typedef logic [15:0] addr_t;        // VRAM or XR word address
    typedef logic [7:0]  byte_t;        // one host bus byte

    // host visible register numbers
    // numbers 1 and 12..15 have no register behind them
    typedef enum logic [3:0] {
        SYS_CTRL = 4'h0,                // status, mem_wait in bit 15
        TIMER    = 4'h2,                // tenth ms timer
        RD_XADDR = 4'h3,                // XR read address
        WR_XADDR = 4'h4,                // XR write address
        XDATA    = 4'h5,                // XR data port
        RD_INCR  = 4'h6,                // VRAM read increment
        RD_ADDR  = 4'h7,                // VRAM read address
        WR_INCR  = 4'h8,                // VRAM write increment
        WR_ADDR  = 4'h9,                // VRAM write address
        DATA     = 4'hA,                // VRAM data port
        DATA_2   = 4'hB                 // VRAM data port alias
    } reg_num_t;

    localparam int TIMER_HZ = 10000;    // one tick per tenth ms

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the register block testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module reg_interface_tb -f files.f -o sim_reg_interface

# the simulator exits non-zero on a fatal check, the log decides
./obj_dir/sim_reg_interface > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
